// File: cpu_core.f
src/cpu_pkg.sv
src/cpu_decode.sv
src/cpu_alu.sv
src/cpu_regs.sv
src/cpu_sequencer.sv
src/cpu_core.sv
test/tb_memory.sv
test/cpu_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: test/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

    localparam int RESET_CYCLES = 3;
    localparam int JAM_WATCH    = 20;   // cycles watched after o_jam rises
    localparam int N_TESTS      = 6;
    localparam int INSTR_BUDGET = 100;  // upper bound on instructions over all tests
    // 4 cycles per instruction worst case plus reset, boot, jam and watch per test
    localparam int MAX_CYCLES   = INSTR_BUDGET * 4
                                + N_TESTS * (1 + RESET_CYCLES + 2 + 2 + JAM_WATCH) + 100;

    logic  clk;
    logic  rst;
    byte_t rdata;
    addr_t bus_addr;
    byte_t bus_wdata;
    logic  bus_rw;
    logic  sync;
    logic  jam;

    // bus observations since reset release
    addr_t sync_addr[$];
    int    sync_cyc[$];
    addr_t wr_addr[$];
    byte_t wr_data[$];
    int    run_cyc;
    int    total_cyc = 0;

    // expected fetch addresses, cycles per instruction and writes
    addr_t exp_addr[$];
    int    exp_cyc[$];
    addr_t exp_wr_addr[$];
    byte_t exp_wr_data[$];

    addr_t pc;          // where the next program byte goes
    byte_t zp_ptr;      // operand data
    addr_t abs_ptr;
    byte_t st_zp;       // store targets
    addr_t st_abs;

    byte_t m_a;         // reference model state
    byte_t m_x;
    byte_t m_y;
    byte_t m_p;

    cpu_core dut0 (
        .i_clk  (clk),
        .i_rst  (rst),
        .i_data (rdata),
        .o_addr (bus_addr),
        .o_data (bus_wdata),
        .o_rw   (bus_rw),
        .o_sync (sync),
        .o_jam  (jam)
    );

    tb_memory mem0 (
        .i_clk   (clk),
        .i_addr  (bus_addr),
        .i_rw    (bus_rw),
        .i_wdata (bus_wdata),
        .o_rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // bus sampled mid-cycle where outputs have settled
    always @(negedge clk) begin
        total_cyc = total_cyc + 1;
        if (rst) begin
            run_cyc = 0;
            sync_addr.delete();
            sync_cyc.delete();
            wr_addr.delete();
            wr_data.delete();
        end else begin
            if (sync) begin
                sync_addr.push_back(bus_addr);
                sync_cyc.push_back(run_cyc);
            end
            if (!bus_rw) begin
                wr_addr.push_back(bus_addr);
                wr_data.push_back(bus_wdata);
            end
            run_cyc = run_cyc + 1;
        end
        if (total_cyc >= MAX_CYCLES) begin
            $display("sim failed");
            $fatal(1, "timeout, core still running after %0d cycles", total_cyc);
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = %h, expected %h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic put_byte(input addr_t addr, input byte_t val);
        mem0.mem[addr] = val;
    endtask

    task automatic put_code(input byte_t val);
        put_byte(pc, val);
        pc = pc + 16'd1;
    endtask

    // holds the core in reset while memory is refilled
    task automatic start_program(input addr_t start);
        @(posedge clk);
        #1 rst = 1'b1;
        for (int a = 0; a < 65536; a++) begin
            mem0.mem[addr_t'(a)] = byte_t'(a >> 8) ^ byte_t'(a) ^ 8'h5a;
        end
        put_byte(RESET_VECTOR, start[7:0]);
        put_byte(RESET_VECTOR + 16'd1, start[15:8]);
        exp_addr.delete();
        exp_cyc.delete();
        exp_wr_addr.delete();
        exp_wr_data.delete();
        pc      = start;
        zp_ptr  = 8'h80;
        abs_ptr = 16'h3000;
        st_zp   = 8'h40;
        st_abs  = 16'h1240;
        m_a     = 8'h00;
        m_x     = 8'h00;
        m_y     = 8'h00;
        m_p     = P_RESET;
    endtask

    task automatic model_nz(input byte_t v);
        m_p[FLAG_N] = v[7];
        m_p[FLAG_Z] = (v == 8'h00);
    endtask

    // plain integer arithmetic where sbc borrows when carry is clear
    task automatic model_addsub(input logic sub, input byte_t b);
        int cin;
        int usum;
        int ssum;
        cin = int'(m_p[FLAG_C]);
        if (sub) begin
            usum = int'(m_a) - int'(b) - (1 - cin);
            ssum = int'($signed(m_a)) - int'($signed(b)) - (1 - cin);
            m_p[FLAG_C] = (usum >= 0);
        end else begin
            usum = int'(m_a) + int'(b) + cin;
            ssum = int'($signed(m_a)) + int'($signed(b)) + cin;
            m_p[FLAG_C] = (usum > 255);
        end
        m_p[FLAG_V] = (ssum > 127) || (ssum < -128);
        m_a = usum[7:0];
    endtask

    task automatic expect_instr(input int cycles);
        exp_addr.push_back(pc);
        exp_cyc.push_back(cycles);
    endtask

    task automatic emit_implied(input byte_t op);
        expect_instr(2);
        put_code(op);
    endtask

    task automatic emit_carry(input logic set);
        emit_implied(set ? 8'h38 : 8'h18);
        m_p[FLAG_C] = set;
    endtask

    // mode 0 immediate, 1 zero page, 2 absolute
    task automatic emit_operand(input byte_t op_imm, input byte_t op_zp, input byte_t op_abs,
                                input int mode, input byte_t val);
        case (mode)
            0: begin
                expect_instr(2);
                put_code(op_imm);
                put_code(val);
            end
            1: begin
                expect_instr(3);
                put_code(op_zp);
                put_code(zp_ptr);
                put_byte({8'h00, zp_ptr}, val);
                zp_ptr = zp_ptr + 8'd1;
            end
            default: begin
                expect_instr(4);
                put_code(op_abs);
                put_code(abs_ptr[7:0]);
                put_code(abs_ptr[15:8]);
                put_byte(abs_ptr, val);
                abs_ptr = abs_ptr + 16'd1;
            end
        endcase
    endtask

    task automatic emit_store(input byte_t op_zp, input byte_t op_abs, input int mode,
                              input byte_t val);
        addr_t dst;
        if (mode == 1) begin
            dst = {8'h00, st_zp};
            expect_instr(3);
            put_code(op_zp);
            put_code(st_zp);
            st_zp = st_zp + 8'd1;
        end else begin
            dst = st_abs;
            expect_instr(4);
            put_code(op_abs);
            put_code(st_abs[7:0]);
            put_code(st_abs[15:8]);
            st_abs = st_abs + 16'd1;
        end
        exp_wr_addr.push_back(dst);
        exp_wr_data.push_back(val);
    endtask

    // r is 0 for a, 1 for x, 2 for y
    task automatic load_reg(input int r, input int mode, input byte_t val);
        case (r)
            0: begin
                emit_operand(8'ha9, 8'ha5, 8'had, mode, val);
                m_a = val;
            end
            1: begin
                emit_operand(8'ha2, 8'ha6, 8'hae, mode, val);
                m_x = val;
            end
            default: begin
                emit_operand(8'ha0, 8'ha4, 8'hac, mode, val);
                m_y = val;
            end
        endcase
        model_nz(val);
    endtask

    task automatic store_reg(input int r, input int mode);
        case (r)
            0:       emit_store(8'h85, 8'h8d, mode, m_a);
            1:       emit_store(8'h86, 8'h8e, mode, m_x);
            default: emit_store(8'h84, 8'h8c, mode, m_y);
        endcase
    endtask

    // op 0 adc, 1 sbc, 2 and, 3 ora, 4 eor
    task automatic emit_alu(input int op, input int mode, input byte_t val);
        byte_t imm;
        case (op)
            0:       imm = 8'h69;
            1:       imm = 8'he9;
            2:       imm = 8'h29;
            3:       imm = 8'h09;
            default: imm = 8'h49;
        endcase
        emit_operand(imm, imm - 8'h04, imm + 8'h04, mode, val);
        case (op)
            0, 1:    model_addsub(op == 1, val);
            2:       m_a = m_a & val;
            3:       m_a = m_a | val;
            default: m_a = m_a ^ val;
        endcase
        model_nz(m_a);
    endtask

    task automatic emit_jmp(input addr_t target);
        expect_instr(3);
        put_code(8'h4c);
        put_code(target[7:0]);
        put_code(target[15:8]);
        pc = target;
    endtask

    // every program ends on an unknown opcode
    task automatic emit_jam(input byte_t op);
        exp_addr.push_back(pc);
        put_code(op);
    endtask

    task automatic run_program();
        int n_sync;
        int n_wr;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        while (sync_addr.size() < exp_addr.size()) @(negedge clk);
        while (!jam) @(negedge clk);
        n_sync = sync_addr.size();
        n_wr   = wr_addr.size();
        repeat (JAM_WATCH) @(negedge clk);
        #1;
        check("o_jam", 32'(jam), 32'd1);
        check("o_sync count after jam", 32'(sync_addr.size()), 32'(n_sync));
        check("write count after jam", 32'(wr_addr.size()), 32'(n_wr));
        check("o_sync count", 32'(sync_addr.size()), 32'(exp_addr.size()));
        check("first o_sync cycle", 32'(sync_cyc[0]), 32'd2);
        for (int i = 0; i < exp_addr.size(); i++) begin
            check("o_addr at o_sync", 32'(sync_addr[i]), 32'(exp_addr[i]));
        end
        for (int i = 0; i < exp_cyc.size(); i++) begin
            check("cycles between o_sync", sync_cyc[i + 1] - sync_cyc[i], exp_cyc[i]);
        end
        check("write count", 32'(wr_addr.size()), 32'(exp_wr_addr.size()));
        for (int i = 0; i < exp_wr_addr.size(); i++) begin
            check("write o_addr", 32'(wr_addr[i]), 32'(exp_wr_addr[i]));
            check("write o_data", 32'(wr_data[i]), 32'(exp_wr_data[i]));
            check("memory byte", 32'(mem0.mem[exp_wr_addr[i]]), 32'(exp_wr_data[i]));
        end
        check("reg a", 32'(dut0.regs0.a), 32'(m_a));
        check("reg x", 32'(dut0.regs0.x), 32'(m_x));
        check("reg y", 32'(dut0.regs0.y), 32'(m_y));
        check("reg p", 32'(dut0.regs0.p), 32'(m_p));
    endtask

    task automatic test_boot();
        addr_t start;
        start = {8'h6c, byte_t'($urandom())};
        start_program(start);
        emit_implied(8'hea);
        emit_carry(1'b1);
        emit_jam(8'h02);
        run_program();
        check("boot fetch address", 32'(sync_addr[0]),
              32'({mem0.mem[RESET_VECTOR + 16'd1], mem0.mem[RESET_VECTOR]}));
    endtask

    task automatic test_load_store();
        start_program(16'h0200);
        for (int i = 0; i < 9; i++) begin
            load_reg(i % 3, i / 3, byte_t'($urandom()));
            store_reg(i % 3, 1 + i % 2);
        end
        emit_jam(8'h02);
        run_program();
    endtask

    task automatic test_arith();
        start_program(16'h0800);
        emit_carry(1'b0);
        load_reg(0, 0, 8'h7f);
        emit_alu(0, 0, 8'h01);      // positive overflow
        store_reg(0, 1);
        emit_carry(1'b1);
        load_reg(0, 0, 8'h80);
        emit_alu(1, 0, 8'h01);      // negative overflow
        store_reg(0, 2);
        for (int i = 0; i < 6; i++) begin
            case ($urandom_range(2, 0))
                0:       emit_carry(1'b0);
                1:       emit_carry(1'b1);
                default: ;          // carry chains on
            endcase
            emit_alu(0, i % 3, byte_t'($urandom()));
            emit_alu(1, (i + 1) % 3, byte_t'($urandom()));
            store_reg(0, 1 + i % 2);
        end
        emit_jam(8'h02);
        run_program();
    endtask

    task automatic test_logic();
        start_program(16'h0a00);
        load_reg(0, 0, byte_t'($urandom()));
        for (int i = 0; i < 9; i++) begin
            emit_alu(2 + i / 3, i % 3, byte_t'($urandom()));
            store_reg(0, 1 + i % 2);
        end
        emit_jam(8'h02);
        run_program();
    endtask

    task automatic test_timing_jump();
        start_program(16'h0c00);
        emit_implied(8'hea);
        load_reg(0, 0, byte_t'($urandom()));
        load_reg(1, 1, byte_t'($urandom()));
        load_reg(2, 2, byte_t'($urandom()));
        emit_carry(1'b1);
        emit_jmp(16'h5a30);
        store_reg(0, 1);
        store_reg(1, 2);
        store_reg(2, 1);
        emit_carry(1'b0);
        emit_jam(8'h3f);
        run_program();
    endtask

    task automatic test_illegal();
        byte_t op;
        case ($urandom_range(3, 0))
            0:       op = 8'h02;
            1:       op = 8'h9c;
            2:       op = 8'hff;
            default: op = 8'h80;
        endcase
        start_program(16'h1800);
        load_reg(0, 0, byte_t'($urandom()));
        store_reg(0, 1);
        emit_jam(op);
        run_program();
    endtask

    initial begin
        rst = 1'b1;
        void'($urandom(32'h746c));
        test_boot();
        test_load_store();
        test_arith();
        test_logic();
        test_timing_jump();
        test_illegal();
        $display("sim passed");
        $finish;
    end

endmodule

// File: test/tb_memory.sv
`timescale 1ns/1ps

module tb_memory import cpu_pkg::*; (
    input  logic  i_clk,
    input  addr_t i_addr,
    input  logic  i_rw,
    input  byte_t i_wdata,
    output byte_t o_rdata
);

    byte_t mem [0:65535];   // full 64 KiB address space

    assign o_rdata = mem[i_addr];   // read data in the same cycle

    always @(posedge i_clk) begin
        if (!i_rw) begin
            mem[i_addr] <= i_wdata;     // write at the end of the cycle
        end
    end

endmodule

// File: src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  byte_t i_data,
    output addr_t o_addr,
    output byte_t o_data,
    output logic  o_rw,
    output logic  o_sync,
    output logic  o_jam
);

    byte_t      opcode;
    ctrl_t      ctrl;
    byte_t      src_val;
    byte_t      alu_result;
    alu_flags_t alu_flags;
    logic       carry;
    logic       exec_we;

    cpu_decode decode0 (
        .i_opcode (opcode),
        .o_ctrl   (ctrl)
    );

    // operand b always comes straight off the data bus
    cpu_alu alu0 (
        .i_op     (ctrl.alu_op),
        .i_a      (src_val),
        .i_b      (i_data),
        .i_carry  (carry),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    cpu_regs regs0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_ctrl    (ctrl),
        .i_we      (exec_we),
        .i_result  (alu_result),
        .i_flags   (alu_flags),
        .o_src_val (src_val),
        .o_carry   (carry)
    );

    cpu_sequencer seq0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_data    (i_data),
        .i_ctrl    (ctrl),
        .i_src_val (src_val),
        .o_opcode  (opcode),
        .o_exec_we (exec_we),
        .o_addr    (o_addr),
        .o_data    (o_data),
        .o_rw      (o_rw),
        .o_sync    (o_sync),
        .o_jam     (o_jam)
    );

endmodule

// File: src/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  byte_t i_data,
    input  ctrl_t i_ctrl,
    input  byte_t i_src_val,
    output byte_t o_opcode,
    output logic  o_exec_we,
    output addr_t o_addr,
    output byte_t o_data,
    output logic  o_rw,
    output logic  o_sync,
    output logic  o_jam
);

    seq_state_e state;
    seq_state_e state_nxt;
    addr_t      pc;
    addr_t      ea;         // operand address with the low byte latched first
    byte_t      opcode;

    always_comb begin
        state_nxt = state;
        o_addr    = pc;
        o_exec_we = 1'b0;

        case (state)
            S_BOOT_LO: begin
                o_addr    = RESET_VECTOR;
                state_nxt = S_BOOT_HI;
            end
            S_BOOT_HI: begin
                o_addr    = RESET_VECTOR + 16'd1;
                state_nxt = S_FETCH;
            end
            S_FETCH: state_nxt = S_DECODE;
            S_DECODE: begin
                if (i_ctrl.illegal) begin
                    state_nxt = S_JAM;
                end else begin
                    case (i_ctrl.mode)
                        ZERO_PAGE:      state_nxt = S_EXEC;
                        ABSOLUTE, JUMP: state_nxt = S_ADDR_HI;
                        default: begin
                            // implied and immediate finish here
                            o_exec_we = 1'b1;
                            state_nxt = S_FETCH;
                        end
                    endcase
                end
            end
            S_ADDR_HI: begin
                o_exec_we = (i_ctrl.mode == JUMP);
                state_nxt = (i_ctrl.mode == JUMP) ? S_FETCH : S_EXEC;
            end
            S_EXEC: begin
                o_addr    = ea;
                o_exec_we = 1'b1;
                state_nxt = S_FETCH;
            end
            S_JAM:   ;          // stopped until reset
            default: state_nxt = S_JAM;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state  <= S_BOOT_LO;
            opcode <= 8'hea;    // nop
        end else begin
            state <= state_nxt;
            if (state == S_FETCH) opcode <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        case (state)
            S_BOOT_LO: ea[7:0] <= i_data;
            S_BOOT_HI: pc <= {i_data, ea[7:0]};
            S_FETCH:   pc <= pc + 16'd1;
            S_DECODE: begin
                ea <= {8'h00, i_data};  // zero page by default
                if (i_ctrl.mode != IMPLIED) pc <= pc + 16'd1;
            end
            S_ADDR_HI: begin
                if (i_ctrl.mode == JUMP) begin
                    pc <= {i_data, ea[7:0]};
                end else begin
                    ea[15:8] <= i_data;
                    pc       <= pc + 16'd1;
                end
            end
            default: ;
        endcase
    end

    assign o_opcode = opcode;
    assign o_data   = i_src_val;
    assign o_rw     = !((state == S_EXEC) && i_ctrl.is_store);
    assign o_sync   = (state == S_FETCH);
    assign o_jam    = (state == S_JAM);

    // a write goes to the operand address in the last cycle of a store
    a_store_last: assert property (@(posedge i_clk) disable iff (i_rst)
        !o_rw |-> (o_exec_we && (o_addr == ea)) ##1 (o_rw && o_sync));

    // opcode fetch is a single read cycle that ends no instruction
    a_sync_fetch: assert property (@(posedge i_clk) disable iff (i_rst)
        o_sync |-> (o_rw && !o_exec_we) ##1 !o_sync);

    a_jam_sticky: assert property (@(posedge i_clk) disable iff (i_rst)
        o_jam |=> o_jam);

endmodule

// File: src/cpu_regs.sv
`timescale 1ns/1ps

module cpu_regs import cpu_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  ctrl_t      i_ctrl,
    input  logic       i_we,
    input  byte_t      i_result,
    input  alu_flags_t i_flags,
    output byte_t      o_src_val,
    output logic       o_carry
);

    byte_t a;
    byte_t x;
    byte_t y;
    byte_t p;
    byte_t p_nxt;

    always_comb begin
        case (i_ctrl.src_reg)
            REG_A:   o_src_val = a;
            REG_X:   o_src_val = x;
            REG_Y:   o_src_val = y;
            default: o_src_val = 8'h00;    // loads pass memory through
        endcase
    end

    always_comb begin
        p_nxt = p;
        if (i_ctrl.flag_mask.n) p_nxt[FLAG_N] = i_flags.n;
        if (i_ctrl.flag_mask.v) p_nxt[FLAG_V] = i_flags.v;
        if (i_ctrl.flag_mask.z) p_nxt[FLAG_Z] = i_flags.z;
        if (i_ctrl.flag_mask.c) p_nxt[FLAG_C] = i_flags.c;

        // explicit carry control wins
        if (i_ctrl.set_c) begin
            p_nxt[FLAG_C] = 1'b1;
        end else if (i_ctrl.clr_c) begin
            p_nxt[FLAG_C] = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            a <= 8'h00;
            x <= 8'h00;
            y <= 8'h00;
            p <= P_RESET;
        end else if (i_we) begin
            case (i_ctrl.dst_reg)
                REG_A:   a <= i_result;
                REG_X:   x <= i_result;
                REG_Y:   y <= i_result;
                default: ;
            endcase
            p <= p_nxt;
        end
    end

    assign o_carry = p[FLAG_C];

    // decoder never requests both carry controls for an executing instruction
    a_carry_ctl: assert property (@(posedge i_clk) disable iff (i_rst)
        i_we |-> !(i_ctrl.set_c && i_ctrl.clr_c));

endmodule

// File: src/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
    input  alu_op_e    i_op,
    input  byte_t      i_a,
    input  byte_t      i_b,
    input  logic       i_carry,
    output byte_t      o_result,
    output alu_flags_t o_flags
);

    byte_t      b_in;
    logic [8:0] sum;

    always_comb begin
        b_in = (i_op == ALU_SUB) ? ~i_b : i_b;  // sbc adds the complement, carry = not borrow
        sum  = {1'b0, i_a} + {1'b0, b_in} + {8'd0, i_carry};

        o_flags.c = i_carry;    // unchanged unless add or subtract
        o_flags.v = 1'b0;       // masked off outside add and subtract

        case (i_op)
            ALU_ADD, ALU_SUB: begin
                o_result  = sum[7:0];
                o_flags.c = sum[8];
                // same operand signs, different result sign
                o_flags.v = (i_a[7] == b_in[7]) && (sum[7] != i_a[7]);
            end
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_EOR: o_result = i_a ^ i_b;
            default: o_result = i_b;
        endcase

        o_flags.n = o_result[7];
        o_flags.z = (o_result == 8'h00);
    end

endmodule

// File: src/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; (
    input  byte_t i_opcode,
    output ctrl_t o_ctrl
);

    logic mem_op;   // opcode takes an operand byte from memory

    always_comb begin
        o_ctrl = '0;    // implied, pass, no registers, flags untouched
        mem_op = 1'b1;

        case (i_opcode)
            // loads
            8'ha9, 8'ha5, 8'had: begin
                o_ctrl.dst_reg   = REG_A;
                o_ctrl.flag_mask = MASK_NZ;
            end
            8'ha2, 8'ha6, 8'hae: begin
                o_ctrl.dst_reg   = REG_X;
                o_ctrl.flag_mask = MASK_NZ;
            end
            8'ha0, 8'ha4, 8'hac: begin
                o_ctrl.dst_reg   = REG_Y;
                o_ctrl.flag_mask = MASK_NZ;
            end

            // stores put the source register on the write bus
            8'h85, 8'h8d: begin
                o_ctrl.src_reg  = REG_A;
                o_ctrl.is_store = 1'b1;
            end
            8'h86, 8'h8e: begin
                o_ctrl.src_reg  = REG_X;
                o_ctrl.is_store = 1'b1;
            end
            8'h84, 8'h8c: begin
                o_ctrl.src_reg  = REG_Y;
                o_ctrl.is_store = 1'b1;
            end

            // accumulator ops
            8'h69, 8'h65, 8'h6d: begin
                o_ctrl.alu_op    = ALU_ADD;
                o_ctrl.flag_mask = MASK_NVZC;
            end
            8'he9, 8'he5, 8'hed: begin
                o_ctrl.alu_op    = ALU_SUB;
                o_ctrl.flag_mask = MASK_NVZC;
            end
            8'h29, 8'h25, 8'h2d: begin
                o_ctrl.alu_op    = ALU_AND;
                o_ctrl.flag_mask = MASK_NZ;
            end
            8'h09, 8'h05, 8'h0d: begin
                o_ctrl.alu_op    = ALU_OR;
                o_ctrl.flag_mask = MASK_NZ;
            end
            8'h49, 8'h45, 8'h4d: begin
                o_ctrl.alu_op    = ALU_EOR;
                o_ctrl.flag_mask = MASK_NZ;
            end

            8'h18: begin
                o_ctrl.clr_c = 1'b1;    // clc
                mem_op       = 1'b0;
            end
            8'h38: begin
                o_ctrl.set_c = 1'b1;    // sec
                mem_op       = 1'b0;
            end
            8'hea: mem_op = 1'b0;       // nop
            8'h4c: begin
                o_ctrl.mode = JUMP;
                mem_op      = 1'b0;
            end
            default: begin
                o_ctrl.illegal = 1'b1;
                mem_op         = 1'b0;
            end
        endcase

        if (o_ctrl.alu_op != ALU_PASS) begin
            o_ctrl.src_reg = REG_A;
            o_ctrl.dst_reg = REG_A;
        end

        // addressing mode sits in opcode bits 3:2 for the memory ops
        if (mem_op) begin
            case (i_opcode[3:2])
                2'b01:   o_ctrl.mode = ZERO_PAGE;
                2'b11:   o_ctrl.mode = ABSOLUTE;
                default: o_ctrl.mode = IMMEDIATE;
            endcase
        end
    end

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    localparam addr_t RESET_VECTOR = 16'hfffc;  // low byte of start address, high byte follows

    // bit positions in p
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_V = 6;
    localparam int FLAG_N = 7;

    localparam byte_t P_RESET = 8'h04;  // interrupt disable set

    typedef enum logic [2:0] {
        IMPLIED,
        IMMEDIATE,
        ZERO_PAGE,
        ABSOLUTE,
        JUMP
    } addr_mode_e;

    typedef enum logic [2:0] {
        ALU_PASS,   // result = b
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_EOR
    } alu_op_e;

    typedef enum logic [1:0] {REG_NONE, REG_A, REG_X, REG_Y} reg_sel_e;

    typedef enum logic [2:0] {
        S_BOOT_LO,
        S_BOOT_HI,
        S_FETCH,
        S_DECODE,
        S_ADDR_HI,
        S_EXEC,
        S_JAM
    } seq_state_e;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } alu_flags_t;

    // flag update masks, n v z c
    localparam alu_flags_t MASK_NZ   = 4'b1010;
    localparam alu_flags_t MASK_NVZC = 4'b1111;

    typedef struct packed {
        addr_mode_e mode;
        alu_op_e    alu_op;
        reg_sel_e   src_reg;
        reg_sel_e   dst_reg;
        logic       is_store;
        alu_flags_t flag_mask;  // flags taken from the alu
        logic       set_c;
        logic       clr_c;
        logic       illegal;
    } ctrl_t;

endpackage
